/* rv_isa_pkg.sv */
package rv_isa_pkg;

  parameter int XLEN = 32;
  parameter int ILEN = 32;

  // Field widths
  parameter int OPCODE_W = 7;
  parameter int FUNCT3_W = 3;
  parameter int FUNCT7_W = 7;
  parameter int IMM_I_W  = 12;
  parameter int IMM_B_W  = 13;
  parameter int IMM_J_W  = 21;

  typedef logic [XLEN-1:0] word_t;

  // Major opcodes kept in this slice
  typedef enum logic [OPCODE_W-1:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [FUNCT3_W-1:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_fn_e;

endpackage

/* pipe_pkg.sv */
package pipe_pkg;

  // Architectural index width, NUM_REGS may use fewer bits
  parameter int REG_IDX_W = 5;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Link address step for JAL/JALR
  parameter int PC_STEP = 4;

  // Extra work in execute besides the ALU
  typedef enum logic [1:0] {
    KIND_NONE   = 2'd0,
    KIND_JUMP   = 2'd1,
    KIND_BRANCH = 2'd2
  } kind_e;

endpackage

/* stage_if.sv */
`timescale 1ns/100ps

interface decode_exec_if;
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  logic     valid;
  logic     ready;
  alu_op_e  alu_op;
  word_t    op1;
  word_t    op2;
  reg_idx_t rd;
  logic     wen;
  kind_e    kind;
  br_fn_e   br_fn;
  word_t    cmp_a;
  word_t    cmp_b;
  word_t    jump_base;
  word_t    jump_off;
  word_t    pc;
  logic     illegal;

  modport src (
    output valid, alu_op, op1, op2, rd, wen, kind, br_fn,
    output cmp_a, cmp_b, jump_base, jump_off, pc, illegal,
    input  ready
  );
  modport snk (
    input  valid, alu_op, op1, op2, rd, wen, kind, br_fn,
    input  cmp_a, cmp_b, jump_base, jump_off, pc, illegal,
    output ready
  );
endinterface

interface exec_result_if;
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  logic     valid;
  logic     ready;
  reg_idx_t rd;
  logic     wen;
  word_t    data;
  logic     redirect;
  word_t    target;
  word_t    pc;
  logic     illegal;

  modport src (output valid, rd, wen, data, redirect, target, pc, illegal, input ready);
  modport snk (input valid, rd, wen, data, redirect, target, pc, illegal, output ready);
endinterface

/* inst_decode.sv */
`timescale 1ns/100ps

module inst_decode #(
  parameter int NUM_REGS = 16
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         inst_valid_i,
  input  logic [rv_isa_pkg::ILEN-1:0]  inst_i,
  input  rv_isa_pkg::word_t            pc_i,
  output logic                         inst_ready_o,
  output pipe_pkg::reg_idx_t           rs1_o,
  output pipe_pkg::reg_idx_t           rs2_o,
  input  rv_isa_pkg::word_t            rdata1_i,
  input  rv_isa_pkg::word_t            rdata2_i,
  input  logic [NUM_REGS-1:0]          busy_i,
  output logic                         issue_o,
  output pipe_pkg::reg_idx_t           issue_rd_o,
  decode_exec_if.src                   ex_o
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  localparam int IDX_W = $clog2(NUM_REGS);

  logic                valid_q;
  logic [ILEN-1:0]     inst_q;
  word_t               pc_q;
  reg_idx_t            rs1, rs2, rd;
  logic [FUNCT3_W-1:0] funct3;
  logic [FUNCT7_W-1:0] funct7;
  logic [IMM_I_W-1:0]  imm_i;
  logic [IMM_B_W-1:0]  imm_b;
  logic [IMM_J_W-1:0]  imm_j;
  word_t               imm_i_x, imm_b_x, imm_j_x, imm_u;
  logic                use_rs1, use_rs2, writes, hazard;

  assign rs1    = inst_q[19:15];
  assign rs2    = inst_q[24:20];
  assign rd     = inst_q[11:7];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];
  assign imm_i  = inst_q[31:20];
  assign imm_b  = {inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_j  = {inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
  assign imm_u  = {inst_q[31:12], 12'b0};

  assign imm_i_x = {{(XLEN-IMM_I_W){imm_i[IMM_I_W-1]}}, imm_i};
  assign imm_b_x = {{(XLEN-IMM_B_W){imm_b[IMM_B_W-1]}}, imm_b};
  assign imm_j_x = {{(XLEN-IMM_J_W){imm_j[IMM_J_W-1]}}, imm_j};

  always_comb begin
    use_rs1       = 1'b0;
    use_rs2       = 1'b0;
    writes        = 1'b0;
    ex_o.alu_op    = ALU_ADD;
    ex_o.op1       = '0;
    ex_o.op2       = '0;
    ex_o.kind      = KIND_NONE;
    ex_o.br_fn     = br_fn_e'(funct3);
    ex_o.cmp_a     = rdata1_i;
    ex_o.cmp_b     = rdata2_i;
    ex_o.jump_base = pc_q;
    ex_o.jump_off  = '0;
    ex_o.illegal   = 1'b0;
    case (opcode_e'(inst_q[OPCODE_W-1:0]))
      OPC_LUI: begin
        writes   = 1'b1;
        ex_o.op2 = imm_u;
      end
      OPC_AUIPC: begin
        writes   = 1'b1;
        ex_o.op1 = pc_q;
        ex_o.op2 = imm_u;
      end
      OPC_JAL: begin
        writes        = 1'b1;
        ex_o.op1      = pc_q; // Link address through the ALU
        ex_o.op2      = word_t'(PC_STEP);
        ex_o.kind     = KIND_JUMP;
        ex_o.jump_off = imm_j_x;
      end
      OPC_JALR: begin
        writes         = 1'b1;
        use_rs1        = 1'b1;
        ex_o.op1       = pc_q;
        ex_o.op2       = word_t'(PC_STEP);
        ex_o.kind      = KIND_JUMP;
        ex_o.jump_base = rdata1_i;
        ex_o.jump_off  = imm_i_x;
      end
      OPC_BRANCH: begin
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        ex_o.kind     = KIND_BRANCH;
        ex_o.jump_off = imm_b_x;
        ex_o.illegal  = (funct3[2:1] == 2'b01); // No BR encoding for 010/011
      end
      OPC_OP_IMM: begin
        writes      = 1'b1;
        use_rs1     = 1'b1;
        ex_o.op1    = rdata1_i;
        ex_o.op2    = imm_i_x;
        ex_o.alu_op = alu_op_e'({(funct3 == 3'b101) ? funct7[5] : 1'b0, funct3});
      end
      OPC_OP: begin
        writes      = 1'b1;
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        ex_o.op1    = rdata1_i;
        ex_o.op2    = rdata2_i;
        ex_o.alu_op = alu_op_e'({funct7[5], funct3});
      end
      default: ex_o.illegal = 1'b1; // Retires with no write
    endcase
  end

  assign ex_o.rd  = rd;
  assign ex_o.wen = writes & (rd != '0);
  assign ex_o.pc  = pc_q;

  // Sources still in flight, or an older write to the same rd
  assign hazard = (use_rs1 & busy_i[rs1[IDX_W-1:0]]) |
                  (use_rs2 & busy_i[rs2[IDX_W-1:0]]) |
                  (ex_o.wen & busy_i[rd[IDX_W-1:0]]);

  assign ex_o.valid   = valid_q & ~hazard;
  assign inst_ready_o = ~valid_q | (~hazard & ex_o.ready);

  assign rs1_o      = rs1;
  assign rs2_o      = rs2;
  assign issue_o    = ex_o.valid & ex_o.ready & ex_o.wen;
  assign issue_rd_o = rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (inst_ready_o) begin
      valid_q <= inst_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid_i && inst_ready_o) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

endmodule

/* int_execute.sv */
`timescale 1ns/100ps

module int_execute (
  input  logic       clk,
  input  logic       rst,
  decode_exec_if.snk ex_i,
  exec_result_if.src res_o
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  word_t    alu_res;
  word_t    sum_tgt;
  logic     taken;
  logic     redirect;
  word_t    target;
  logic [4:0] shamt;

  logic     valid_q;
  reg_idx_t rd_q;
  logic     wen_q;
  word_t    data_q;
  logic     redirect_q;
  word_t    target_q;
  word_t    pc_q;
  logic     illegal_q;

  assign shamt = ex_i.op2[4:0];

  always_comb begin
    case (ex_i.alu_op)
      ALU_ADD:  alu_res = ex_i.op1 + ex_i.op2;
      ALU_SUB:  alu_res = ex_i.op1 - ex_i.op2;
      ALU_SLL:  alu_res = ex_i.op1 << shamt;
      ALU_SLT:  alu_res = word_t'($signed(ex_i.op1) < $signed(ex_i.op2));
      ALU_SLTU: alu_res = word_t'(ex_i.op1 < ex_i.op2);
      ALU_XOR:  alu_res = ex_i.op1 ^ ex_i.op2;
      ALU_SRL:  alu_res = ex_i.op1 >> shamt;
      ALU_SRA:  alu_res = word_t'($signed(ex_i.op1) >>> shamt);
      ALU_OR:   alu_res = ex_i.op1 | ex_i.op2;
      ALU_AND:  alu_res = ex_i.op1 & ex_i.op2;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (ex_i.br_fn)
      BR_EQ:   taken = (ex_i.cmp_a == ex_i.cmp_b);
      BR_NE:   taken = (ex_i.cmp_a != ex_i.cmp_b);
      BR_LT:   taken = ($signed(ex_i.cmp_a) < $signed(ex_i.cmp_b));
      BR_GE:   taken = ($signed(ex_i.cmp_a) >= $signed(ex_i.cmp_b));
      BR_LTU:  taken = (ex_i.cmp_a < ex_i.cmp_b);
      BR_GEU:  taken = (ex_i.cmp_a >= ex_i.cmp_b);
      default: taken = 1'b0;
    endcase
  end

  assign sum_tgt  = ex_i.jump_base + ex_i.jump_off;
  assign redirect = (ex_i.kind == KIND_JUMP) |
                    ((ex_i.kind == KIND_BRANCH) & taken & ~ex_i.illegal);
  // JALR drops bit 0, branch and JAL targets are already even
  assign target   = redirect ? {sum_tgt[XLEN-1:1], 1'b0} : '0;

  // One-entry buffer, refills while draining
  assign ex_i.ready = ~valid_q | res_o.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (ex_i.ready) begin
      valid_q <= ex_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_i.valid && ex_i.ready) begin
      rd_q       <= ex_i.rd;
      wen_q      <= ex_i.wen;
      data_q     <= alu_res;
      redirect_q <= redirect;
      target_q   <= target;
      pc_q       <= ex_i.pc;
      illegal_q  <= ex_i.illegal;
    end
  end

  assign res_o.valid    = valid_q;
  assign res_o.rd       = rd_q;
  assign res_o.wen      = wen_q;
  assign res_o.data     = data_q;
  assign res_o.redirect = redirect_q;
  assign res_o.target   = target_q;
  assign res_o.pc       = pc_q;
  assign res_o.illegal  = illegal_q;

endmodule

/* reg_result.sv */
`timescale 1ns/100ps

module reg_result #(
  parameter int NUM_REGS = 16
) (
  input  logic                clk,
  input  logic                rst,
  exec_result_if.snk          res_i,
  input  pipe_pkg::reg_idx_t  rs1_i,
  input  pipe_pkg::reg_idx_t  rs2_i,
  output rv_isa_pkg::word_t   rdata1_o,
  output rv_isa_pkg::word_t   rdata2_o,
  output logic [NUM_REGS-1:0] busy_o,
  input  logic                issue_i,
  input  pipe_pkg::reg_idx_t  issue_rd_i,
  input  logic                retire_ready_i,
  output logic                retire_valid_o,
  output rv_isa_pkg::word_t   retire_pc_o,
  output pipe_pkg::reg_idx_t  retire_rd_o,
  output logic                retire_wen_o,
  output rv_isa_pkg::word_t   retire_data_o,
  output logic                retire_redirect_o,
  output rv_isa_pkg::word_t   retire_target_o,
  output logic                retire_illegal_o
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  localparam int IDX_W = $clog2(NUM_REGS);

  word_t               regs [NUM_REGS];
  logic [NUM_REGS-1:0] busy_q;
  logic                ret_valid_q;
  logic                retire_fire;

  assign res_i.ready = ~ret_valid_q | retire_ready_i;
  assign retire_fire = ret_valid_q & retire_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_valid_q <= 1'b0;
    end else if (res_i.ready) begin
      ret_valid_q <= res_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (res_i.valid && res_i.ready) begin
      retire_pc_o       <= res_i.pc;
      retire_rd_o       <= res_i.rd;
      retire_wen_o      <= res_i.wen;
      retire_data_o     <= res_i.data;
      retire_redirect_o <= res_i.redirect;
      retire_target_o   <= res_i.target;
      retire_illegal_o  <= res_i.illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
      busy_q <= '0;
    end else begin
      if (retire_fire && retire_wen_o && retire_rd_o != '0) begin
        regs[retire_rd_o[IDX_W-1:0]]   <= retire_data_o;
        busy_q[retire_rd_o[IDX_W-1:0]] <= 1'b0;
      end
      if (issue_i && issue_rd_i != '0) begin
        busy_q[issue_rd_i[IDX_W-1:0]] <= 1'b1; // New owner wins
      end
    end
  end

  // x0 hardwired
  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i[IDX_W-1:0]];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i[IDX_W-1:0]];

  assign busy_o         = busy_q;
  assign retire_valid_o = ret_valid_q;

endmodule

/* core_slice_top.sv */
`timescale 1ns/100ps

module core_slice_top #(
  parameter int NUM_REGS = 16
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                inst_valid_i,
  input  logic [rv_isa_pkg::ILEN-1:0]         inst_i,
  input  logic [rv_isa_pkg::XLEN-1:0]         pc_i,
  output logic                                inst_ready_o,
  input  logic                                retire_ready_i,
  output logic                                retire_valid_o,
  output logic [rv_isa_pkg::XLEN-1:0]         retire_pc_o,
  output logic [pipe_pkg::REG_IDX_W-1:0]      retire_rd_o,
  output logic                                retire_wen_o,
  output logic [rv_isa_pkg::XLEN-1:0]         retire_data_o,
  output logic                                retire_redirect_o,
  output logic [rv_isa_pkg::XLEN-1:0]         retire_target_o,
  output logic                                retire_illegal_o
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  reg_idx_t            rs1, rs2;
  word_t               rdata1, rdata2;
  logic [NUM_REGS-1:0] busy;
  logic                issue;
  reg_idx_t            issue_rd;

  decode_exec_if de_if ();
  exec_result_if er_if ();

  inst_decode #(.NUM_REGS(NUM_REGS)) u_decode (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .inst_ready_o (inst_ready_o),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .busy_i       (busy),
    .issue_o      (issue),
    .issue_rd_o   (issue_rd),
    .ex_o         (de_if.src)
  );

  int_execute u_execute (
    .clk   (clk),
    .rst   (rst),
    .ex_i  (de_if.snk),
    .res_o (er_if.src)
  );

  reg_result #(.NUM_REGS(NUM_REGS)) u_result (
    .clk               (clk),
    .rst               (rst),
    .res_i             (er_if.snk),
    .rs1_i             (rs1),
    .rs2_i             (rs2),
    .rdata1_o          (rdata1),
    .rdata2_o          (rdata2),
    .busy_o            (busy),
    .issue_i           (issue),
    .issue_rd_i        (issue_rd),
    .retire_ready_i    (retire_ready_i),
    .retire_valid_o    (retire_valid_o),
    .retire_pc_o       (retire_pc_o),
    .retire_rd_o       (retire_rd_o),
    .retire_wen_o      (retire_wen_o),
    .retire_data_o     (retire_data_o),
    .retire_redirect_o (retire_redirect_o),
    .retire_target_o   (retire_target_o),
    .retire_illegal_o  (retire_illegal_o)
  );

endmodule

/* tb_core_slice.sv */
`timescale 1ns/100ps

module tb_core_slice;
  parameter int NUM_REGS = 16;
  localparam int WAIT_LIMIT = 500;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        wen;
    logic [31:0] data;
    logic        redirect;
    logic [31:0] target;
    logic        illegal;
  } exp_t;

  logic        clk;
  logic        rst;
  logic        inst_valid_i;
  logic [31:0] inst_i;
  logic [31:0] pc_i;
  logic        inst_ready_o;
  logic        retire_ready_i;
  logic        retire_valid_o;
  logic [31:0] retire_pc_o;
  logic [4:0]  retire_rd_o;
  logic        retire_wen_o;
  logic [31:0] retire_data_o;
  logic        retire_redirect_o;
  logic [31:0] retire_target_o;
  logic        retire_illegal_o;

  exp_t        exp_q[$];
  logic [31:0] mregs [NUM_REGS];
  logic [31:0] stim_state;
  logic [31:0] bp_state;
  logic        bp_on;
  int          errors;
  int          checks;
  int          accepted;
  int          retired;

  core_slice_top #(.NUM_REGS(NUM_REGS)) dut0 (
    .clk               (clk),
    .rst               (rst),
    .inst_valid_i      (inst_valid_i),
    .inst_i            (inst_i),
    .pc_i              (pc_i),
    .inst_ready_o      (inst_ready_o),
    .retire_ready_i    (retire_ready_i),
    .retire_valid_o    (retire_valid_o),
    .retire_pc_o       (retire_pc_o),
    .retire_rd_o       (retire_rd_o),
    .retire_wen_o      (retire_wen_o),
    .retire_data_o     (retire_data_o),
    .retire_redirect_o (retire_redirect_o),
    .retire_target_o   (retire_target_o),
    .retire_illegal_o  (retire_illegal_o)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] draw_rand();
    stim_state = next_rand(stim_state);
    return stim_state;
  endfunction

  function automatic logic [31:0] reg_read(input logic [4:0] idx);
    if (idx == 5'd0 || int'(idx) >= NUM_REGS) return 32'd0;
    return mregs[idx];
  endfunction

  // RV32I integer ops by funct3 with alt selecting SUB/SRA
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    logic [31:0] sra;
    sra = $signed(x) >>> y[4:0];
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return {31'd0, $signed(x) < $signed(y)};
      3'd3: return {31'd0, x < y};
      3'd4: return x ^ y;
      3'd5: return alt ? sra : x >> y[4:0];
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
    case (f3)
      3'd0: return x == y;
      3'd1: return x != y;
      3'd4: return $signed(x) < $signed(y);
      3'd5: return $signed(x) >= $signed(y);
      3'd6: return x < y;
      default: return x >= y;
    endcase
  endfunction

  // Kind codes 0 OP-IMM, 1 OP, 2 LUI, 3 AUIPC, 4 JAL, 5 JALR, 6 BRANCH, 7 unknown
  function automatic logic [31:0] build_inst(input int kind, input int span);
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [6:0]  opc;
    int          idx;
    r   = draw_rand();
    rd  = 5'(draw_rand() % span);
    rs1 = 5'(draw_rand() % span);
    rs2 = 5'(draw_rand() % span);
    f3  = r[14:12];
    case (kind)
      0: begin
        imm = r[31:20];
        if (f3 == 3'd1) imm = {7'h00, r[24:20]};
        if (f3 == 3'd5) imm = {(r[30] ? 7'h20 : 7'h00), r[24:20]};
        return {imm, rs1, f3, rd, 7'h13};
      end
      1: begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00;
        return {f7, rs2, rs1, f3, rd, 7'h33};
      end
      2: return {r[31:12], rd, 7'h37};
      3: return {r[31:12], rd, 7'h17};
      4: return {r[31:12], rd, 7'h6f};
      5: return {r[31:20], rs1, 3'b000, rd, 7'h67};
      6: begin
        idx = int'(draw_rand() % 6);
        f3  = (idx < 2) ? 3'(idx) : 3'(idx + 2);  // Skip 010 and 011
        return {r[31:25], rs2, rs1, f3, r[11:7], 7'h63};
      end
      default: begin
        case (r[1:0])
          2'd0: opc = 7'h03;
          2'd1: opc = 7'h23;
          2'd2: opc = 7'h73;
          default: opc = 7'h0f;
        endcase
        return {r[31:7], opc};
      end
    endcase
  endfunction

  // In-order ISA reference updated at acceptance
  task automatic model_accept(input logic [31:0] inst, input logic [31:0] pc);
    exp_t        e;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] val;
    logic        wr;
    a     = reg_read(inst[19:15]);
    b     = reg_read(inst[24:20]);
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_u = {inst[31:12], 12'd0};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    val   = 32'd0;
    wr    = 1'b0;
    e     = '0;
    e.pc  = pc;
    e.rd  = inst[11:7];
    case (inst[6:0])
      7'h37: begin
        wr  = 1'b1;
        val = imm_u;
      end
      7'h17: begin
        wr  = 1'b1;
        val = pc + imm_u;
      end
      7'h6f: begin
        wr         = 1'b1;
        val        = pc + 32'd4;
        e.redirect = 1'b1;
        e.target   = pc + imm_j;
      end
      7'h67: begin
        wr         = 1'b1;
        val        = pc + 32'd4;
        e.redirect = 1'b1;
        e.target   = (a + imm_i) & ~32'd1;
      end
      7'h63: begin
        e.redirect = branch_taken(inst[14:12], a, b);
        e.target   = pc + imm_b;
      end
      7'h13: val = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'd5, a, imm_i);
      7'h33: begin
        wr  = 1'b1;
        val = alu_ref(inst[14:12], inst[30], a, b);
      end
      default: e.illegal = 1'b1;
    endcase
    if (inst[6:0] == 7'h13) wr = 1'b1;
    e.wen  = wr && (e.rd != 5'd0);
    e.data = val;
    if (e.wen) mregs[e.rd] = val;
    exp_q.push_back(e);
    accepted++;
  endtask

  task automatic check_val(input string what, input logic [31:0] got,
                           input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR t=%0t %s: got %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_retire();
    exp_t e;
    retired++;
    if (exp_q.size() == 0) begin
      errors++;
      $display("Retire at %0t with no instruction outstanding", $time);
    end else begin
      e = exp_q.pop_front();
      check_val("retire pc", retire_pc_o, e.pc);
      check_val("illegal flag", 32'(retire_illegal_o), 32'(e.illegal));
      check_val("write enable", 32'(retire_wen_o), 32'(e.wen));
      check_val("redirect", 32'(retire_redirect_o), 32'(e.redirect));
      if (e.wen) begin
        check_val("rd", 32'(retire_rd_o), 32'(e.rd));
        check_val("rd data", retire_data_o, e.data);
      end
      if (e.redirect) check_val("target", retire_target_o, e.target);
    end
  endtask

  // Both handshakes are stable between negedge and the next posedge
  always @(negedge clk) begin
    if (!rst) begin
      if (retire_valid_o && retire_ready_i) check_retire();
      if (inst_valid_i && inst_ready_o) model_accept(inst_i, pc_i);
    end
  end

  always @(posedge clk) begin
    bp_state = next_rand(bp_state);
    retire_ready_i <= bp_on ? (bp_state[1:0] != 2'd0) : 1'b1;  // Low about 1 in 4
  end

  task automatic abort_run(input string why);
    $display("Timeout at %0t: %s", $time, why);
    $display("Done: errors found");
    $finish;
  endtask

  // Returns at the negedge before the transfer edge
  task automatic send_inst(input logic [31:0] inst, input logic [31:0] pc);
    int waited;
    @(posedge clk);
    inst_valid_i <= 1'b1;
    inst_i       <= inst;
    pc_i         <= pc;
    waited = 0;
    @(negedge clk);
    while (!inst_ready_o) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("instruction was never accepted");
      @(negedge clk);
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    inst_valid_i <= 1'b0;
  endtask

  task automatic drain_pipe();
    int waited;
    waited = 0;
    idle_cycle();
    @(negedge clk);
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("pipeline did not drain");
      @(negedge clk);
    end
  endtask

  task automatic run_test(input int id, input string name, input int count,
                          input logic [7:0] kinds, input int span, input logic bp,
                          input logic lead_x0);
    int          err0;
    int          acc0;
    int          ret0;
    int          k;
    logic [31:0] pc;
    err0  = errors;
    acc0  = accepted;
    ret0  = retired;
    bp_on = bp;
    if (lead_x0) begin
      send_inst({12'h123, 5'd0, 3'b000, 5'd0, 7'h13}, 32'h0000_1000);  // addi x0
      send_inst({7'h00, 5'd0, 5'd0, 3'b000, 5'd1, 7'h33}, 32'h0000_1004);
      send_inst(32'h0000_0073, 32'h0000_1008);
    end
    for (int n = 0; n < count; n++) begin
      k = int'(draw_rand() % 8);
      while (!kinds[k]) k = (k + 1) % 8;
      pc = draw_rand() & 32'hffff_fffc;
      send_inst(build_inst(k, span), pc);
      if (bp && (draw_rand() % 8) == 0) idle_cycle();
    end
    drain_pipe();
    bp_on = 1'b0;
    check_val("retire count", 32'(retired - ret0), 32'(accepted - acc0));
    $display("Test %0d %s: %0d accepted, %0d retired, %0d errors",
             id, name, accepted - acc0, retired - ret0, errors - err0);
  endtask

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    inst_valid_i   = 1'b0;
    inst_i         = 32'd0;
    pc_i           = 32'd0;
    retire_ready_i = 1'b1;
    bp_on          = 1'b0;
    stim_state     = 32'd44;
    bp_state       = next_rand(32'd44);
    errors         = 0;
    checks         = 0;
    accepted       = 0;
    retired        = 0;
    for (int i = 0; i < NUM_REGS; i++) mregs[i] = 32'd0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    run_test(1, "alu ops", 80, 8'b0000_0011, NUM_REGS, 1'b0, 1'b0);
    run_test(2, "dependent chains", 80, 8'b0000_0011, 4, 1'b0, 1'b0);
    run_test(3, "upper imm and jumps", 60, 8'b0011_1100, NUM_REGS, 1'b0, 1'b0);
    run_test(4, "branches", 80, 8'b0100_0001, 4, 1'b1, 1'b0);
    run_test(5, "backpressure and illegal", 150, 8'b1111_1111, NUM_REGS, 1'b1, 1'b1);
    $display("Summary: %0d checks, %0d errors, %0d accepted, %0d retired",
             checks, errors, accepted, retired);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* vlog.f */
rv_isa_pkg.sv
pipe_pkg.sv
stage_if.sv
inst_decode.sv
int_execute.sv
reg_result.sv
core_slice_top.sv
tb_core_slice.sv

/* Makefile */
# Verilator simulation of the RV32 pipeline slice

VERILATOR ?= verilator
TOP       ?= tb_core_slice
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# Pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
